//--- include/tcdm_cfg.svh
// Build-time configuration of the TCDM interconnect.
// Included by the package and by every RTL module that sizes ports or arrays.
// Master and bank counts are expected to be powers of two.

`ifndef TCDM_CFG_SVH
`define TCDM_CFG_SVH

// ******************************
// Port and bank counts
// ******************************
`define TCDM_NB_MASTERS 4 // Request ports
`define TCDM_NB_BANKS 4 // Word-interleaved banks

// ******************************
// Widths
// ******************************
`define TCDM_DATA_WIDTH 32 // Word width
`define TCDM_ADDR_WIDTH 32 // Byte address width
`define TCDM_ROW_WIDTH 8 // Word index inside one bank

// Derived sizes
`define TCDM_BE_WIDTH ((`TCDM_DATA_WIDTH) / 8)
`define TCDM_BYTE_OFF_WIDTH ($clog2(`TCDM_BE_WIDTH))
`define TCDM_BANK_IDX_WIDTH ($clog2(`TCDM_NB_BANKS))
`define TCDM_MASTER_ID_WIDTH ($clog2(`TCDM_NB_MASTERS))
`define TCDM_BANK_DEPTH (1 << `TCDM_ROW_WIDTH) // Words per bank

`endif

//--- design/tcdm_pkg.sv
// Shared types of the TCDM interconnect.
// Request and response bundles are packed structs so that they travel as one port.
// The address helpers define the word interleaving used by every bank.

`include "tcdm_cfg.svh"

package tcdm_pkg;

  // ******************************
  // Plain vector types
  // ******************************
  typedef logic [`TCDM_DATA_WIDTH-1:0]      data_t;
  typedef logic [`TCDM_ADDR_WIDTH-1:0]      addr_t;
  typedef logic [`TCDM_BE_WIDTH-1:0]        be_t;
  typedef logic [`TCDM_BANK_IDX_WIDTH-1:0]  bank_idx_t; // Selects a bank
  typedef logic [`TCDM_ROW_WIDTH-1:0]       row_t;      // Word inside a bank
  typedef logic [`TCDM_MASTER_ID_WIDTH-1:0] master_id_t;
  typedef logic [`TCDM_NB_MASTERS-1:0]      master_vec_t; // One bit per master

  // ******************************
  // Bus bundles
  // ******************************
  typedef struct packed {
    logic  req;
    addr_t add;
    logic  wen;   // High for read
    data_t wdata;
    be_t   be;
  } tcdm_req_t;

  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    data_t r_rdata;
  } tcdm_rsp_t;

  // Bank response tagged with the requesting master
  typedef struct packed {
    logic       r_valid;
    data_t      r_rdata;
    master_id_t r_id;
  } bank_rsp_t;

  // Bank bits sit just above the byte offset
  function automatic bank_idx_t get_bank(addr_t add);
    return add[`TCDM_BYTE_OFF_WIDTH +: `TCDM_BANK_IDX_WIDTH];
  endfunction

  function automatic row_t get_row(addr_t add);
    return add[`TCDM_BYTE_OFF_WIDTH + `TCDM_BANK_IDX_WIDTH +: `TCDM_ROW_WIDTH];
  endfunction

endpackage

//--- design/tcdm_req_router.sv
// Request side of the TCDM crossbar.
// Decodes the target bank of every active master request and builds, for each
// bank, the mask of masters that address it. Purely combinational.

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tcdm_req_router
  import tcdm_pkg::*;
(
  input  tcdm_req_t   req_i      [`TCDM_NB_MASTERS],
  output master_vec_t hit_mask_o [`TCDM_NB_BANKS]
);

  // ******************************
  // Bank decode per master
  // ******************************
  bank_idx_t   target_bank [`TCDM_NB_MASTERS]; // Bank addressed by each master
  master_vec_t active;                         // Masters with a pending request

  generate
    for (genvar m = 0; m < `TCDM_NB_MASTERS; m++)
    begin : gen_decode
      assign target_bank[m] = get_bank(req_i[m].add);
      assign active[m]      = req_i[m].req;
    end
  endgenerate

  // ******************************
  // Hit masks per bank
  // ******************************
  // A master lands in exactly one mask, and only while it requests
  generate
    for (genvar b = 0; b < `TCDM_NB_BANKS; b++)
    begin : gen_bank
      for (genvar m = 0; m < `TCDM_NB_MASTERS; m++)
      begin : gen_master
        assign hit_mask_o[b][m] = active[m] &&
                                  (target_bank[m] == bank_idx_t'(b));
      end
    end
  endgenerate

endmodule

//--- design/tcdm_bank_slice.sv
// One bank of the TCDM crossbar.
// Round-robin arbitration among the masters in the hit mask, a single-port word
// array with byte-masked writes, and a response register one cycle after grant.
// The grant is combinational from the hit mask in the request cycle.

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tcdm_bank_slice
  import tcdm_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  tcdm_req_t   req_i [`TCDM_NB_MASTERS],
  input  master_vec_t hit_mask_i,
  output master_vec_t gnt_o,
  output bank_rsp_t   rsp_o
);

  master_id_t rr_ptr_q;  // Master with the highest priority
  master_id_t rr_ptr_d;
  master_id_t gnt_idx;   // Winner of this cycle
  logic       any_hit;

  tcdm_req_t  sel_req;
  row_t       sel_row;

  data_t      mem [`TCDM_BANK_DEPTH];
  data_t      rdata_q;
  logic       r_valid_q;
  master_id_t r_id_q;

  // ******************************
  // Round-robin arbiter
  // ******************************
  assign any_hit = |hit_mask_i;

  // Search upward from the pointer and wrap around
  always_comb
  begin
    int unsigned cand;
    logic        found;
    gnt_idx = rr_ptr_q;
    found   = 1'b0;
    for (int i = 0; i < `TCDM_NB_MASTERS; i++)
    begin
      cand = (int'(rr_ptr_q) + i) % `TCDM_NB_MASTERS;
      if (!found && hit_mask_i[cand])
      begin
        gnt_idx = master_id_t'(cand);
        found   = 1'b1;
      end
    end
  end

  always_comb
  begin
    gnt_o = '0;
    if (any_hit)
      gnt_o[gnt_idx] = 1'b1; // One-hot to the winner
  end

  // Next priority goes to the master after the one just granted
  assign rr_ptr_d = gnt_idx + 1'b1; // Wraps past the last master

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rr_ptr_q <= '0;
    else if (any_hit)
      rr_ptr_q <= rr_ptr_d;
  end

  // ******************************
  // Word array
  // ******************************
  assign sel_req = req_i[gnt_idx];
  assign sel_row = get_row(sel_req.add);

  // Byte-masked write
  always_ff @(posedge clk_i)
  begin
    if (any_hit && !sel_req.wen)
    begin
      for (int b = 0; b < `TCDM_BE_WIDTH; b++)
      begin
        if (sel_req.be[b])
          mem[sel_row][8*b +: 8] <= sel_req.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (any_hit && sel_req.wen)
      rdata_q <= mem[sel_row]; // Held until the next read
  end

  // ******************************
  // Response register
  // ******************************
  // Reads and writes alike answer one cycle after grant
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      r_valid_q <= 1'b0;
      r_id_q    <= '0;
    end
    else
    begin
      r_valid_q <= any_hit;
      if (any_hit)
        r_id_q <= gnt_idx; // Tag for the return path
    end
  end

  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_rdata = rdata_q;
  assign rsp_o.r_id    = r_id_q;

endmodule

//--- design/tcdm_resp_router.sv
// Response side of the TCDM crossbar.
// Merges the per-bank grant vectors into one gnt per master and steers every
// valid bank response back to the master named by its id. Purely combinational.

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tcdm_resp_router
  import tcdm_pkg::*;
(
  input  master_vec_t gnt_i      [`TCDM_NB_BANKS],
  input  bank_rsp_t   bank_rsp_i [`TCDM_NB_BANKS],
  output tcdm_rsp_t   rsp_o      [`TCDM_NB_MASTERS]
);

  // Per master, the banks whose current response belongs to it
  logic [`TCDM_NB_BANKS-1:0] rsp_hit [`TCDM_NB_MASTERS];
  // Per master, the banks granting it this cycle
  logic [`TCDM_NB_BANKS-1:0] gnt_hit [`TCDM_NB_MASTERS];

  // ******************************
  // Match matrix
  // ******************************
  generate
    for (genvar m = 0; m < `TCDM_NB_MASTERS; m++)
    begin : gen_master
      for (genvar b = 0; b < `TCDM_NB_BANKS; b++)
      begin : gen_bank
        assign gnt_hit[m][b] = gnt_i[b][m];
        assign rsp_hit[m][b] = bank_rsp_i[b].r_valid &&
                               (bank_rsp_i[b].r_id == master_id_t'(m));
      end
    end
  endgenerate

  // ******************************
  // Output merge
  // ******************************
  // A master is granted by at most one bank, so one hit at most per row
  always_comb
  begin
    for (int m = 0; m < `TCDM_NB_MASTERS; m++)
    begin
      rsp_o[m].gnt     = |gnt_hit[m];
      rsp_o[m].r_valid = |rsp_hit[m];
      rsp_o[m].r_rdata = '0;
      for (int b = 0; b < `TCDM_NB_BANKS; b++)
      begin
        if (rsp_hit[m][b])
          rsp_o[m].r_rdata = bank_rsp_i[b].r_rdata;
      end
    end
  end

endmodule

//--- design/tcdm_xbar.sv
// Top level of the word-interleaved TCDM crossbar with internal banks.
// Each master presents a tcdm_req_t and gets back gnt and a response one cycle
// after acceptance. Requests to different banks proceed in parallel.

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tcdm_xbar
  import tcdm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  tcdm_req_t req_i [`TCDM_NB_MASTERS],
  output tcdm_rsp_t rsp_o [`TCDM_NB_MASTERS]
);

  master_vec_t hit_mask [`TCDM_NB_BANKS]; // Masters addressing each bank
  master_vec_t bank_gnt [`TCDM_NB_BANKS]; // Grant vector of each bank
  bank_rsp_t   bank_rsp [`TCDM_NB_BANKS];

  // ******************************
  // Request decode
  // ******************************
  tcdm_req_router i_req_router (
    .req_i      ( req_i    ),
    .hit_mask_o ( hit_mask )
  );

  // ******************************
  // Banks
  // ******************************
  generate
    for (genvar b = 0; b < `TCDM_NB_BANKS; b++)
    begin : gen_bank
      tcdm_bank_slice i_bank_slice (
        .clk_i      ( clk_i       ),
        .rst_ni     ( rst_ni      ),
        .req_i      ( req_i       ),
        .hit_mask_i ( hit_mask[b] ),
        .gnt_o      ( bank_gnt[b] ),
        .rsp_o      ( bank_rsp[b] )
      );
    end
  endgenerate

  // ******************************
  // Response return
  // ******************************
  tcdm_resp_router i_resp_router (
    .gnt_i      ( bank_gnt ),
    .bank_rsp_i ( bank_rsp ),
    .rsp_o      ( rsp_o    )
  );

endmodule

//--- verification/tcdm_clk_gen.sv
// Clock and reset source for the TCDM testbench.
// The clock starts low. Reset is held low for RESET_CYCLES periods and is
// released on a falling edge, away from the active clock edge.

`timescale 1ns/1ps

module tcdm_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial
  begin
    clk_o = 1'b0;
    forever
      #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_no = 1'b0;
    #(PERIOD_NS * RESET_CYCLES) rst_no = 1'b1; // Lands on a falling edge
  end

endmodule

//--- verification/tcdm_xbar_tb.sv
// Testbench of the TCDM crossbar.
// Applies a table of per-master requests one row at a time on the falling edge.
// A master of a row keeps requesting until granted, then the next row starts.
// Grants are checked against a round-robin model per bank, responses against a
// behavioral word memory with byte enables.

`timescale 1ns/1ps

`include "tcdm_cfg.svh"

module tcdm_xbar_tb
  import tcdm_pkg::*;
();

  localparam int NM      = `TCDM_NB_MASTERS;
  localparam int NB      = `TCDM_NB_BANKS;
  localparam int BE_W    = `TCDM_BE_WIDTH;
  localparam int PERIOD  = 100;
  localparam int RST_CYC = 5;
  localparam int MARGIN  = 20; // Spare cycles before the watchdog fires

  // One table row, one lane per master
  typedef struct packed {
    master_vec_t    req;
    master_vec_t    wen; // High for read
    addr_t [NM-1:0] add;
    be_t   [NM-1:0] be;
  } step_t;

  logic        clk;
  logic        rst_n;
  tcdm_req_t   req_drv [NM];
  tcdm_rsp_t   rsp_mon [NM];

  step_t       table_q [$];
  logic        table_ready;
  logic [31:0] lfsr_q;
  tcdm_req_t   cur_req [NM];   // Current row fields driven at the falling edge
  master_vec_t pending;        // Row masters not granted yet
  int          rr_ptr [NB];    // Highest priority master per bank
  data_t       mem_model [int];
  master_vec_t exp_valid;      // Responses due at the next falling edge
  master_vec_t exp_read;
  data_t       exp_data [NM];

  tcdm_clk_gen #(
    .PERIOD_NS    ( PERIOD  ),
    .RESET_CYCLES ( RST_CYC )
  ) i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  tcdm_xbar dut0 (
    .clk_i  ( clk     ),
    .rst_ni ( rst_n   ),
    .req_i  ( req_drv ),
    .rsp_o  ( rsp_mon )
  );

  // ******************************
  // Compare tasks
  // ******************************
  task automatic check_bit(string name, logic act, logic exp);
    if (act !== exp)
    begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, act, exp);
      $display("TB FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_vec(string name, master_vec_t act, master_vec_t exp);
    if (act !== exp)
    begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, act, exp);
      $display("TB FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_data(string name, data_t act, data_t exp);
    if (act !== exp)
    begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, act, exp);
      $display("TB FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // ******************************
  // Helpers
  // ******************************
  // The bank is the word address modulo the bank count
  function automatic int bank_of(addr_t a);
    return (a / BE_W) % NB;
  endfunction

  function automatic int word_of(addr_t a);
    return a / BE_W;
  endfunction

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic data_t rand_word();
    data_t w;
    for (int i = 0; i < `TCDM_DATA_WIDTH; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      w[i]   = lfsr_q[0];
    end
    return w;
  endfunction

  function automatic step_t lane(step_t s, int m, addr_t a, logic rd, be_t be);
    step_t r;
    r        = s;
    r.req[m] = 1'b1;
    r.wen[m] = rd;
    r.add[m] = a;
    r.be[m]  = be;
    return r;
  endfunction

  task automatic build_table();
    step_t s;
    s = lane('0, 0, 32'h010, 1'b0, 4'hf); // Write then read on master 0
    table_q.push_back(s);
    table_q.push_back('0);
    table_q.push_back(lane('0, 0, 32'h010, 1'b1, 4'h0));
    table_q.push_back(lane('0, 1, 32'h020, 1'b0, 4'hf)); // Byte enables on one word
    table_q.push_back(lane('0, 1, 32'h020, 1'b0, 4'h1));
    table_q.push_back(lane('0, 1, 32'h020, 1'b0, 4'h6));
    table_q.push_back(lane('0, 1, 32'h020, 1'b0, 4'h8));
    table_q.push_back(lane('0, 1, 32'h020, 1'b1, 4'h0));
    for (int pass = 0; pass < 2; pass++)
    begin
      s = '0; // Each master on its own bank
      for (int m = 0; m < NM; m++)
        s = lane(s, m, 32'h100 + 4 * ((m + 1) % NB), pass[0], 4'hf);
      table_q.push_back(s);
    end
    s = '0; // All masters on bank 2
    for (int m = 0; m < NM; m++)
      s = lane(s, m, 32'h208 + 16 * m, 1'b0, 4'hf);
    table_q.push_back(s);
    s = '0;
    for (int m = 0; m < NM; m++)
      s = lane(s, m, 32'h208 + 16 * ((m + 2) % NM), 1'b1, 4'h0);
    table_q.push_back(s);
    s = lane('0, 0, 32'h218, 1'b1, 4'h0); // Reads race partial writes
    s = lane(s, 1, 32'h218, 1'b0, 4'h3);
    s = lane(s, 2, 32'h238, 1'b1, 4'h0);
    s = lane(s, 3, 32'h238, 1'b0, 4'hc);
    table_q.push_back(s);
    s = lane('0, 1, 32'h238, 1'b1, 4'h0); // Read back the merged words
    table_q.push_back(lane(s, 3, 32'h218, 1'b1, 4'h0));
    for (int k = 0; k < NB; k++) // Back to back on master 2
      table_q.push_back(lane('0, 2, 32'h100 + 4 * k, 1'b1, 4'h0));
    s = lane('0, 3, 32'h010, 1'b1, 4'h0);
    table_q.push_back(lane(s, 0, 32'h020, 1'b1, 4'h0));
  endtask

  // ******************************
  // Cycle engine
  // ******************************
  task automatic start_row(step_t s);
    pending = s.req;
    for (int m = 0; m < NM; m++)
    begin
      if (s.req[m])
      begin
        cur_req[m].add = s.add[m];
        cur_req[m].wen = s.wen[m];
        cur_req[m].be  = s.be[m];
        if (s.wen[m])
          cur_req[m].wdata = '0;
        else
          cur_req[m].wdata = rand_word();
      end
    end
  endtask

  task automatic check_idle();
    for (int m = 0; m < NM; m++)
    begin
      check_bit($sformatf("rsp_o[%0d].gnt", m), rsp_mon[m].gnt, 1'b0);
      check_bit($sformatf("rsp_o[%0d].r_valid", m), rsp_mon[m].r_valid, 1'b0);
    end
  endtask

  task automatic check_responses();
    for (int m = 0; m < NM; m++)
    begin
      check_bit($sformatf("rsp_o[%0d].r_valid", m), rsp_mon[m].r_valid, exp_valid[m]);
      if (exp_read[m])
        check_data($sformatf("rsp_o[%0d].r_rdata", m), rsp_mon[m].r_rdata, exp_data[m]);
    end
  endtask

  // Winner per bank is the first requester counting up from the pointer
  function automatic master_vec_t predict_grants();
    master_vec_t g;
    int          m;
    logic        found;
    g = '0;
    for (int b = 0; b < NB; b++)
    begin
      found = 1'b0;
      for (int k = 0; k < NM; k++)
      begin
        m = (rr_ptr[b] + k) % NM;
        if (!found && pending[m] && bank_of(req_drv[m].add) == b)
        begin
          g[m]  = 1'b1;
          found = 1'b1;
        end
      end
    end
    return g;
  endfunction

  task automatic accept_grants(master_vec_t g);
    int    w;
    data_t merged;
    exp_valid = g;
    exp_read  = '0;
    for (int m = 0; m < NM; m++)
    begin
      if (g[m])
      begin
        w = word_of(req_drv[m].add);
        rr_ptr[bank_of(req_drv[m].add)] = (m + 1) % NM;
        if (req_drv[m].wen && !mem_model.exists(w))
        begin
          $display("TB FAILED");
          $fatal(1, "Master %0d reads word %0d that was never written", m, w);
        end
        else if (req_drv[m].wen)
        begin
          exp_read[m] = 1'b1;
          exp_data[m] = mem_model[w];
        end
        else
        begin
          merged = mem_model.exists(w) ? mem_model[w] : 'x;
          for (int k = 0; k < BE_W; k++)
            if (req_drv[m].be[k])
              merged[8*k +: 8] = req_drv[m].wdata[8*k +: 8];
          mem_model[w] = merged;
        end
      end
    end
    pending = pending & ~g;
  endtask

  task automatic run_cycle();
    master_vec_t act;
    master_vec_t exp;
    @(negedge clk);
    check_responses(); // Due from the grants of the last cycle
    for (int m = 0; m < NM; m++)
    begin
      req_drv[m]     = cur_req[m];
      req_drv[m].req = pending[m];
    end
    #(PERIOD / 10); // Let the combinational grant settle
    exp = predict_grants();
    for (int m = 0; m < NM; m++)
      act[m] = rsp_mon[m].gnt;
    check_vec("rsp_o[*].gnt", act, exp);
    accept_grants(exp);
  endtask

  // ******************************
  // Main sequence
  // ******************************
  initial
  begin
    table_ready = 1'b0;
    lfsr_q      = 32'ha49e_1f2c;
    pending     = '0;
    exp_valid   = '0;
    exp_read    = '0;
    for (int m = 0; m < NM; m++)
    begin
      req_drv[m]  = '0;
      cur_req[m]  = '0;
      exp_data[m] = '0;
    end
    for (int b = 0; b < NB; b++)
      rr_ptr[b] = 0;
    build_table();
    table_ready = 1'b1;
    repeat (RST_CYC - 1)
    begin
      @(negedge clk);
      check_idle();
    end
    wait (rst_n === 1'b1);
    repeat (2)
      run_cycle(); // Idle after reset
    foreach (table_q[i])
    begin
      start_row(table_q[i]);
      do
        run_cycle();
      while (pending != '0);
    end
    repeat (2)
      run_cycle(); // Drain the last responses
    $display("TB PASSED");
    $finish;
  end

  // Bound is four cycles per row plus reset and spare cycles
  initial
  begin : watchdog
    longint limit_ns;
    wait (table_ready === 1'b1);
    limit_ns = longint'(table_q.size() * 4 + RST_CYC + MARGIN) * PERIOD;
    #(limit_ns);
    $display("TB FAILED");
    $fatal(1, "The run timed out after %0d ns", limit_ns);
  end

endmodule

//--- tcdm_xbar.f
+incdir+include
design/tcdm_pkg.sv
design/tcdm_req_router.sv
design/tcdm_bank_slice.sv
design/tcdm_resp_router.sv
design/tcdm_xbar.sv
verification/tcdm_clk_gen.sv
verification/tcdm_xbar_tb.sv
